/* design/fifo_host_pkg.sv */
// Shared sizes, register map and types for the FIFO host
// FIFO geometry is fixed at 16 x 12 bits; AXI4-Lite data is 32 bits wide
package fifo_host_pkg;

    localparam int data_width  = 12;
    localparam int fifo_depth  = 16;
    localparam int count_width = 5;
    localparam int ptr_width   = 4;

    // Sequence generator
    localparam int lfsr_width = 24;
    localparam int seq_width  = 8;
    localparam logic [lfsr_width-1:0] lfsr_seed_default = 24'hABCDEF;
    localparam int lfsr_tap_a = 23;
    localparam int lfsr_tap_b = 17;
    localparam int lfsr_tap_c = 5;

    localparam int flush_cnt_width = 16;

    // AXI4-Lite register map
    localparam int axi_addr_width = 4;
    localparam int axi_data_width = 32;
    localparam logic [axi_addr_width-1:0] reg_ctrl      = 4'h0;
    localparam logic [axi_addr_width-1:0] reg_pattern   = 4'h4;
    localparam logic [axi_addr_width-1:0] reg_status    = 4'h8;
    localparam logic [axi_addr_width-1:0] reg_flush_cnt = 4'hC;

    typedef enum logic [1:0] {
        axi_okay   = 2'b00,
        axi_slverr = 2'b10
    } axi_resp_e;

    // Shared by the write and the read channel FSMs
    typedef enum logic [1:0] {
        reg_idle,
        reg_ack,
        reg_resp
    } reg_state_e;

    typedef struct packed {
        logic                 flush_enable;
        logic [seq_width-1:0] pattern;
        logic                 seed_reload;
    } host_ctrl_t;

    typedef struct packed {
        logic [count_width-1:0]     count;
        logic                       full;
        logic                       empty;
        logic [flush_cnt_width-1:0] flush_cnt;
    } host_status_t;

endpackage

/* design/fifo_host_regs.sv */
// AXI4-Lite slave, one outstanding write and one outstanding read
// AWPROT/ARPROT are not ported; only byte lane 0 of WSTRB matters
`timescale 1ns/10ps

module fifo_host_regs
    import fifo_host_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic [axi_addr_width-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [axi_data_width-1:0] s_axi_wdata,
    input  logic [3:0]                s_axi_wstrb,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,

    input  logic [axi_addr_width-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [axi_data_width-1:0] s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,

    input  host_status_t              status,
    output host_ctrl_t                ctrl
);

    reg_state_e                wr_state;
    reg_state_e                rd_state;
    axi_resp_e                 bresp_q;
    axi_resp_e                 rresp_q;
    logic [axi_data_width-1:0] rd_word;
    logic                      wr_fire;
    logic                      rd_fire;

    function automatic logic addr_mapped(input logic [axi_addr_width-1:0] addr);
        return (addr == reg_ctrl) || (addr == reg_pattern) ||
               (addr == reg_status) || (addr == reg_flush_cnt);
    endfunction

    // Ready and valid come straight from the channel state
    assign s_axi_awready = (wr_state == reg_ack);
    assign s_axi_wready  = (wr_state == reg_ack);
    assign s_axi_bvalid  = (wr_state == reg_resp);
    assign s_axi_bresp   = bresp_q;
    assign s_axi_arready = (rd_state == reg_ack);
    assign s_axi_rvalid  = (rd_state == reg_resp);
    assign s_axi_rresp   = rresp_q;

    assign wr_fire = (wr_state == reg_ack) && s_axi_awvalid && s_axi_wvalid;
    assign rd_fire = (rd_state == reg_ack) && s_axi_arvalid;

    // Write channel and control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_state <= reg_idle;
            bresp_q  <= axi_okay;
            ctrl     <= '0;
        end else begin
            // Reload request lives for a single cycle
            ctrl.seed_reload <= 1'b0;
            case (wr_state)
                reg_idle: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        wr_state <= reg_ack;
                    end
                end
                reg_ack: begin
                    if (wr_fire) begin
                        wr_state <= reg_resp;
                        bresp_q  <= addr_mapped(s_axi_awaddr) ? axi_okay : axi_slverr;
                        if (s_axi_wstrb[0] && s_axi_awaddr == reg_ctrl) begin
                            ctrl.flush_enable <= s_axi_wdata[0];
                            ctrl.seed_reload  <= s_axi_wdata[1];
                        end
                        if (s_axi_wstrb[0] && s_axi_awaddr == reg_pattern) begin
                            ctrl.pattern <= s_axi_wdata[seq_width-1:0];
                        end
                    end
                end
                reg_resp: begin
                    if (s_axi_bready) begin
                        wr_state <= reg_idle;
                    end
                end
                default: wr_state <= reg_idle;
            endcase
        end
    end

    // Read mux, status is sampled at the AR handshake
    always_comb begin
        rd_word = '0;
        case (s_axi_araddr)
            reg_ctrl:      rd_word[0] = ctrl.flush_enable;
            reg_pattern:   rd_word[seq_width-1:0] = ctrl.pattern;
            reg_status: begin
                rd_word[count_width-1:0] = status.count;
                rd_word[8]               = status.empty;
                rd_word[9]               = status.full;
            end
            reg_flush_cnt: rd_word[flush_cnt_width-1:0] = status.flush_cnt;
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= reg_idle;
            rresp_q  <= axi_okay;
        end else begin
            case (rd_state)
                reg_idle: begin
                    if (s_axi_arvalid) begin
                        rd_state <= reg_ack;
                    end
                end
                reg_ack: begin
                    if (rd_fire) begin
                        rd_state <= reg_resp;
                        rresp_q  <= addr_mapped(s_axi_araddr) ? axi_okay : axi_slverr;
                    end
                end
                reg_resp: begin
                    if (s_axi_rready) begin
                        rd_state <= reg_idle;
                    end
                end
                default: rd_state <= reg_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
        end
    end

endmodule

/* design/fifo_host_top.sv */
// FIFO host with a register-controlled, counted flush on LFSR pattern match
// Single clock domain; flush is off after reset
`timescale 1ns/10ps

module fifo_host_top
    import fifo_host_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic [data_width-1:0]     write_data,
    input  logic                      write_enable,
    input  logic                      read_enable,
    output logic [data_width-1:0]     read_data,
    output logic                      valid,
    output logic                      fifo_full,
    output logic                      fifo_empty,

    input  logic [axi_addr_width-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [axi_data_width-1:0] s_axi_wdata,
    input  logic [3:0]                s_axi_wstrb,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [axi_addr_width-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [axi_data_width-1:0] s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready
);

    host_ctrl_t                 ctrl;
    host_status_t               status;
    logic [seq_width-1:0]       seq_byte;
    logic [flush_cnt_width-1:0] flush_cnt;
    logic [count_width-1:0]     count;
    logic                       flush;
    logic                       access;

    // Any FIFO request advances the sequence, accepted or not
    assign access = write_enable | read_enable;

    assign status.count     = count;
    assign status.full      = fifo_full;
    assign status.empty     = fifo_empty;
    assign status.flush_cnt = flush_cnt;

    fifo_host_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .status        (status),
        .ctrl          (ctrl)
    );

    seq_gen u_seq (
        .clk      (clk),
        .rst      (rst),
        .access   (access),
        .reload   (ctrl.seed_reload),
        .seq_byte (seq_byte)
    );

    flush_detector u_det (
        .clk       (clk),
        .rst       (rst),
        .seq_byte  (seq_byte),
        .stepped   (access),
        .ctrl      (ctrl),
        .flush     (flush),
        .flush_cnt (flush_cnt)
    );

    sync_fifo u_fifo (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .read_data    (read_data),
        .valid        (valid),
        .fifo_full    (fifo_full),
        .fifo_empty   (fifo_empty),
        .count        (count)
    );

endmodule

/* design/flush_detector.sv */
// Pattern match on the LFSR byte, checked the cycle after a step
// flush_cnt saturates at 16'hFFFF and only clears on reset
`timescale 1ns/10ps

module flush_detector
    import fifo_host_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [seq_width-1:0]       seq_byte,
    input  logic                       stepped,
    input  host_ctrl_t                 ctrl,
    output logic                       flush,
    output logic [flush_cnt_width-1:0] flush_cnt
);

    logic step_pending;
    logic fire;

    // seq_byte already holds the post-step value here
    assign fire = step_pending && ctrl.flush_enable && (seq_byte == ctrl.pattern);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_pending <= 1'b0;
            flush        <= 1'b0;
            flush_cnt    <= '0;
        end else begin
            // A reload on the same edge replaces the step
            step_pending <= stepped && !ctrl.seed_reload;
            flush        <= fire;
            if (fire && flush_cnt != '1) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/seq_gen.sv */
// Fibonacci LFSR, one step per FIFO access
// Reload wins over a step on the same edge
`timescale 1ns/10ps

module seq_gen
    import fifo_host_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 access,
    input  logic                 reload,
    output logic [seq_width-1:0] seq_byte
);

    logic [lfsr_width-1:0] lfsr;
    logic                  feedback;

    // Taps 23, 17, 5 shifted in at bit 0
    assign feedback = lfsr[lfsr_tap_a] ^ lfsr[lfsr_tap_b] ^ lfsr[lfsr_tap_c];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= lfsr_seed_default;
        end else if (reload) begin
            lfsr <= lfsr_seed_default;
        end else if (access) begin
            lfsr <= {lfsr[lfsr_width-2:0], feedback};
        end
    end

    assign seq_byte = lfsr[seq_width-1:0];

endmodule

/* design/sync_fifo.sv */
// 16 x 12 synchronous FIFO, flags registered from the next count
// Flush beats any write or read on the same edge
`timescale 1ns/10ps

module sync_fifo
    import fifo_host_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic [data_width-1:0]  write_data,
    input  logic                   write_enable,
    input  logic                   read_enable,
    output logic [data_width-1:0]  read_data,
    output logic                   valid,
    output logic                   fifo_full,
    output logic                   fifo_empty,
    output logic [count_width-1:0] count
);

    logic [data_width-1:0]  mem [fifo_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count_next;
    logic                   wr_ok;
    logic                   rd_ok;

    assign wr_ok = write_enable && !fifo_full && !flush;
    assign rd_ok = read_enable && !fifo_empty && !flush;

    always_comb begin
        count_next = count;
        if (flush) begin
            count_next = '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count_next = count + 1'b1;
                2'b01:   count_next = count - 1'b1;
                default: count_next = count;
            endcase
        end
    end

    // Pointers wrap naturally at depth 16
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            valid      <= 1'b0;
            fifo_full  <= 1'b0;
            fifo_empty <= 1'b1;
        end else begin
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (wr_ok) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (rd_ok) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            count      <= count_next;
            valid      <= rd_ok;
            fifo_full  <= (count_next == count_width'(fifo_depth));
            fifo_empty <= (count_next == '0);
        end
    end

    // Storage and output word
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= write_data;
        end
        if (rd_ok) begin
            read_data <= mem[rd_ptr];
        end
    end

endmodule

/* fifo_host.f */
design/fifo_host_pkg.sv
design/fifo_host_regs.sv
design/seq_gen.sv
design/flush_detector.sv
design/sync_fifo.sv
design/fifo_host_top.sv
test/fifo_host_asserts.sv
test/fifo_host_tb.sv

/* test/fifo_host_asserts.sv */
// Concurrent checks bound into fifo_host_top
// fail_count is read by the testbench for its closing summary
`timescale 1ns/10ps

module fifo_host_asserts
    import fifo_host_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input logic                      read_enable,
    input logic                      valid,
    input logic                      fifo_empty,
    input logic                      flush,
    input logic [count_width-1:0]    count,
    input logic                      s_axi_bvalid,
    input logic                      s_axi_bready,
    input logic [1:0]                s_axi_bresp,
    input logic                      s_axi_rvalid,
    input logic                      s_axi_rready,
    input logic [1:0]                s_axi_rresp,
    input logic [axi_data_width-1:0] s_axi_rdata
);

    int fail_count = 0;

    // Valid only after a read that found data and was not flushed
    a_valid_after_read: assert property (@(posedge clk) disable iff (rst)
        valid |-> $past(read_enable && !fifo_empty && !flush))
    else begin
        $error("valid high without an accepted read on the previous edge");
        fail_count++;
    end

    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush |=> fifo_empty && (count == '0))
    else begin
        $error("FIFO not empty on the cycle after a flush");
        fail_count++;
    end

    // Responses wait for the master, unchanged
    a_b_held: assert property (@(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
    else begin
        $error("write response dropped or changed before BREADY");
        fail_count++;
    end

    a_r_held: assert property (@(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=>
            s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
    else begin
        $error("read response dropped or changed before RREADY");
        fail_count++;
    end

endmodule

bind fifo_host_top fifo_host_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .read_enable  (read_enable),
    .valid        (valid),
    .fifo_empty   (fifo_empty),
    .flush        (flush),
    .count        (count),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rdata  (s_axi_rdata)
);

/* test/fifo_host_tb.sv */
// Testbench for fifo_host_top with a FIFO queue model and an LFSR model
// One FIFO op or AXI transaction at a time; flush prediction assumes idle inputs meanwhile
`timescale 1ns/10ps

module fifo_host_tb
    import fifo_host_pkg::*;
();

    localparam int clk_period      = 4;
    localparam int n_random_ops    = 200;
    localparam int n_axi           = 24;
    localparam int watchdog_cycles = (n_random_ops + 80) * 6 + n_axi * 12 + 500;

    logic                      clk;
    logic                      rst;
    logic [data_width-1:0]     write_data;
    logic                      write_enable;
    logic                      read_enable;
    logic [data_width-1:0]     read_data;
    logic                      valid;
    logic                      fifo_full;
    logic                      fifo_empty;
    logic [axi_addr_width-1:0] s_axi_awaddr;
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    logic [axi_data_width-1:0] s_axi_wdata;
    logic [3:0]                s_axi_wstrb;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    logic [1:0]                s_axi_bresp;
    logic                      s_axi_bvalid;
    logic                      s_axi_bready;
    logic [axi_addr_width-1:0] s_axi_araddr;
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    logic [axi_data_width-1:0] s_axi_rdata;
    logic [1:0]                s_axi_rresp;
    logic                      s_axi_rvalid;
    logic                      s_axi_rready;

    integer                seed = 32'h8eb60689;
    int                    errors = 0;
    logic [data_width-1:0] model_q [$];
    logic [lfsr_width-1:0] model_lfsr;
    logic                  model_flush_en;
    logic [seq_width-1:0]  model_pattern;
    int                    model_flushes;

    fifo_host_top u_dut (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: stimulus did not finish within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // Taps 23, 17, 5 with the new bit entering at bit 0
    function automatic logic [lfsr_width-1:0] lfsr_next(input logic [lfsr_width-1:0] cur);
        return {cur[lfsr_width-2:0], cur[23] ^ cur[17] ^ cur[5]};
    endfunction

    function automatic logic [seq_width-1:0] byte_after(input int steps);
        logic [lfsr_width-1:0] v;
        v = model_lfsr;
        repeat (steps) v = lfsr_next(v);
        return v[seq_width-1:0];
    endfunction

    task automatic fifo_op(input logic we, input logic re);
        logic [data_width-1:0] wdata;
        logic [data_width-1:0] head;
        logic                  rd_ok;
        logic                  wr_ok;
        logic                  hit;
        wdata = data_width'($random(seed));
        rd_ok = re && (model_q.size() > 0);
        wr_ok = we && (model_q.size() < fifo_depth);
        head  = rd_ok ? model_q[0] : '0;
        @(posedge clk);
        write_enable <= we;
        read_enable  <= re;
        write_data   <= wdata;
        @(posedge clk);
        write_enable <= 1'b0;
        read_enable  <= 1'b0;
        @(negedge clk);
        if (rd_ok) void'(model_q.pop_front());
        if (wr_ok) model_q.push_back(wdata);
        check_value("valid", valid, rd_ok);
        if (rd_ok) check_value("read_data", read_data, head);
        check_value("fifo_empty", fifo_empty, model_q.size() == 0);
        check_value("fifo_full", fifo_full, model_q.size() == fifo_depth);
        hit = 1'b0;
        if (we || re) begin
            model_lfsr = lfsr_next(model_lfsr);
            hit = model_flush_en && (model_lfsr[seq_width-1:0] == model_pattern);
        end
        if (hit) begin
            // Flush one cycle after the access, FIFO cleared on the edge after that
            repeat (2) @(posedge clk);
            @(negedge clk);
            model_q.delete();
            model_flushes++;
            check_value("fifo_empty", fifo_empty, 1'b1);
        end
    endtask

    task automatic reg_write(input logic [axi_addr_width-1:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        @(posedge clk);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= 4'hF;
        s_axi_wvalid  <= 1'b1;
        @(posedge clk);
        while (!(s_axi_awready && s_axi_wready)) @(posedge clk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        @(posedge clk);
        while (!s_axi_bvalid) @(posedge clk);
        // One cycle of back-pressure on B
        @(posedge clk);
        s_axi_bready <= 1'b1;
        @(posedge clk);
        check_value("s_axi_bresp", s_axi_bresp, exp_resp);
        s_axi_bready <= 1'b0;
    endtask

    task automatic reg_check(input logic [axi_addr_width-1:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
        @(posedge clk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        @(posedge clk);
        while (!s_axi_arready) @(posedge clk);
        s_axi_arvalid <= 1'b0;
        @(posedge clk);
        while (!s_axi_rvalid) @(posedge clk);
        @(posedge clk);
        s_axi_rready <= 1'b1;
        @(posedge clk);
        check_value("s_axi_rresp", s_axi_rresp, exp_resp);
        if (exp_resp == axi_okay) check_value("s_axi_rdata", s_axi_rdata, exp_data);
        s_axi_rready <= 1'b0;
    endtask

    function automatic logic [31:0] status_word();
        logic [31:0] w;
        w = '0;
        w[count_width-1:0] = model_q.size();
        w[8] = (model_q.size() == 0);
        w[9] = (model_q.size() == fifo_depth);
        return w;
    endfunction

    initial begin : stimulus
        rst           = 1'b1;
        write_data    = '0;
        write_enable  = 1'b0;
        read_enable   = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        model_lfsr     = lfsr_seed_default;
        model_flush_en = 1'b0;
        model_pattern  = '0;
        model_flushes  = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("fifo_empty", fifo_empty, 1'b1);
        check_value("fifo_full", fifo_full, 1'b0);
        check_value("valid", valid, 1'b0);

        // Random traffic with flush off
        repeat (n_random_ops) fifo_op(1'($random(seed)), 1'($random(seed)));

        // Drain, fill past full, then drain past empty
        while (model_q.size() > 0) fifo_op(1'b0, 1'b1);
        repeat (fifo_depth + 1) fifo_op(1'b1, 1'b0);
        reg_check(reg_status, status_word(), axi_okay);
        fifo_op(1'b1, 1'b1);
        repeat (fifo_depth + 1) fifo_op(1'b0, 1'b1);

        // Register map and unmapped addresses
        reg_write(reg_pattern, 32'hA5, axi_okay);
        model_pattern = 8'hA5;
        reg_check(reg_pattern, 32'hA5, axi_okay);
        reg_write(reg_ctrl, 32'h1, axi_okay);
        reg_check(reg_ctrl, 32'h1, axi_okay);
        reg_write(reg_ctrl, 32'h0, axi_okay);
        reg_check(reg_ctrl, 32'h0, axi_okay);
        reg_write(4'h2, 32'hFFFF, axi_slverr);
        reg_check(4'h6, 32'h0, axi_slverr);
        reg_check(reg_flush_cnt, 32'h0, axi_okay);

        // Flush on a predicted sequence byte
        model_pattern = byte_after(3);
        reg_write(reg_pattern, 32'(model_pattern), axi_okay);
        reg_write(reg_ctrl, 32'h1, axi_okay);
        model_flush_en = 1'b1;
        repeat (5) fifo_op(1'b1, 1'b0);
        reg_check(reg_flush_cnt, model_flushes, axi_okay);

        // Seed reload, then predict the next match from the seed
        reg_write(reg_ctrl, 32'h3, axi_okay);
        model_lfsr = lfsr_seed_default;
        reg_check(reg_ctrl, 32'h1, axi_okay);
        model_pattern = byte_after(2);
        reg_write(reg_pattern, 32'(model_pattern), axi_okay);
        repeat (4) fifo_op(1'b1, 1'b0);
        reg_check(reg_flush_cnt, model_flushes, axi_okay);
        reg_check(reg_status, status_word(), axi_okay);

        $display("Summary: %0d data errors, %0d assertion failures", errors,
                 u_dut.u_asserts.fail_count);
        if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
